/* design/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // ********************
    // Widths and constants
    // ********************

    localparam int xlen = 32;

    // Sequential pc increment.
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // ********************
    // Operation encodings
    // ********************

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } br_op_e;

    typedef enum logic [1:0] {
        sys_none,
        sys_ecall,
        sys_mret
    } sys_op_e;

    // ********************
    // Stage records
    // ********************

    // Decoded instruction from the decode stage.
    typedef struct packed {
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        br_op_e          br_op;
        sys_op_e         sys_op;
        logic            halt;
    } dec_to_exu_t;

    // Register and CSR operands.
    typedef struct packed {
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mepc;
    } reg_to_exu_t;

    // Record handed on to load/store.
    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
        logic            halt;
    } exu_to_lsu_t;

endpackage

`default_nettype wire

/* design/exec_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] result
);

    logic [4:0]      shamt;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic [xlen-1:0] shl;
    logic [xlen-1:0] shr_logic;
    logic [xlen-1:0] shr_arith;
    logic            lt_signed;
    logic            lt_unsigned;

    // ********************
    // Shared datapath
    // ********************

    // Only the low five bits of b shift.
    assign shamt = b[4:0];

    assign sum  = a + b;
    assign diff = a - b;

    assign shl       = a << shamt;
    assign shr_logic = a >> shamt;
    assign shr_arith = $signed(a) >>> shamt;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // ********************
    // Result select
    // ********************

    always_comb begin
        result = '0;
        case (op)
            alu_add: begin
                result = sum;
            end
            alu_sub: begin
                result = diff;
            end
            alu_sll: begin
                result = shl;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_srl: begin
                result = shr_logic;
            end
            alu_sra: begin
                result = shr_arith;
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            // LUI uses this with b as the immediate.
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/exec_branch.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_branch import exec_pkg::*; (
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] mtvec,
    input  logic [xlen-1:0] mepc,
    input  br_op_e          br_op,
    input  sys_op_e         sys_op,
    output logic [xlen-1:0] next_pc,
    output logic [xlen-1:0] link
);

    logic            eq;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            taken;
    logic [xlen-1:0] snpc;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] jalr_target;

    // ********************
    // Branch condition
    // ********************

    assign eq          = src1 == src2;
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (br_op)
            br_beq:  taken = eq;
            br_bne:  taken = !eq;
            br_blt:  taken = lt_signed;
            br_bge:  taken = !lt_signed;
            br_bltu: taken = lt_unsigned;
            br_bgeu: taken = !lt_unsigned;
            default: taken = 1'b0;
        endcase
    end

    // ********************
    // Next pc
    // ********************

    assign snpc      = pc + pc_step;
    assign pc_target = pc + imm;

    // JALR target has bit 0 forced low.
    assign jalr_target = (src1 + imm) & ~{{(xlen-1){1'b0}}, 1'b1};

    // Traps win over any control-flow op.
    always_comb begin
        if (sys_op == sys_ecall) begin
            next_pc = mtvec;
        end else if (sys_op == sys_mret) begin
            next_pc = mepc;
        end else if (br_op == br_jal) begin
            next_pc = pc_target;
        end else if (br_op == br_jalr) begin
            next_pc = jalr_target;
        end else if (taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = snpc;
        end
    end

    // Return address for JAL and JALR.
    assign link = snpc;

endmodule

`default_nettype wire

/* design/exec_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_stage import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    // Upstream handshake.
    input  logic            in_valid,
    output logic            in_ready,
    input  dec_to_exu_t     dec,
    input  reg_to_exu_t     ops,
    input  logic [xlen-1:0] pc,

    // Downstream handshake.
    output logic            out_valid,
    input  logic            out_ready,
    output exu_to_lsu_t     lsu,
    output logic [xlen-1:0] dnpc,

    // ALU side.
    output logic [xlen-1:0] alu_a,
    output logic [xlen-1:0] alu_b,
    output alu_op_e         alu_op,
    input  logic [xlen-1:0] alu_result,

    // Branch unit side.
    output logic [xlen-1:0] br_pc,
    output logic [xlen-1:0] br_imm,
    output reg_to_exu_t     br_ops,
    output br_op_e          br_op,
    output sys_op_e         sys_op,
    input  logic [xlen-1:0] next_pc,
    input  logic [xlen-1:0] link
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_e;

    state_e          state;
    logic            accept;
    logic            is_jump;
    exu_to_lsu_t     lsu_d;

    dec_to_exu_t     dec_q;
    reg_to_exu_t     ops_q;
    logic [xlen-1:0] pc_q;

    // ********************
    // Input side
    // ********************

    assign in_ready = (state == st_idle);
    assign accept   = in_valid && in_ready;

    // Instruction held for the whole busy period.
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q <= dec;
            ops_q <= ops;
            pc_q  <= pc;
        end
    end

    // ********************
    // Unit operands
    // ********************

    assign alu_a  = dec_q.src1_is_pc ? pc_q : ops_q.src1;
    assign alu_b  = dec_q.src2_is_imm ? dec_q.imm : ops_q.src2;
    assign alu_op = dec_q.alu_op;

    assign br_pc  = pc_q;
    assign br_imm = dec_q.imm;
    assign br_ops = ops_q;
    assign br_op  = dec_q.br_op;
    assign sys_op = dec_q.sys_op;

    // ********************
    // Output merge
    // ********************

    // Jumps write the return address.
    assign is_jump = (dec_q.br_op == br_jal) || (dec_q.br_op == br_jalr);

    always_comb begin
        lsu_d.result     = is_jump ? link : alu_result;
        lsu_d.store_data = ops_q.src2;
        lsu_d.halt       = dec_q.halt;
    end

    // ********************
    // Control FSM
    // ********************

    // Busy spends one cycle computing, then waits for the consumer.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            out_valid <= 1'b0;
            lsu       <= '0;
            dnpc      <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (!out_valid) begin
                        lsu       <= lsu_d;
                        dnpc      <= next_pc;
                        out_valid <= 1'b1;
                    end else if (out_ready) begin
                        out_valid <= 1'b0;
                        state     <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/exec_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit_top import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  dec_to_exu_t     dec,
    input  reg_to_exu_t     ops,
    input  logic [xlen-1:0] pc,
    output logic            out_valid,
    input  logic            out_ready,
    output exu_to_lsu_t     lsu,
    output logic [xlen-1:0] dnpc
);

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    alu_op_e         alu_op;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] br_pc;
    logic [xlen-1:0] br_imm;
    reg_to_exu_t     br_ops;
    br_op_e          br_op;
    sys_op_e         sys_op;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] link;

    exec_stage u_stage (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .dec        (dec),
        .ops        (ops),
        .pc         (pc),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .lsu        (lsu),
        .dnpc       (dnpc),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .br_pc      (br_pc),
        .br_imm     (br_imm),
        .br_ops     (br_ops),
        .br_op      (br_op),
        .sys_op     (sys_op),
        .next_pc    (next_pc),
        .link       (link)
    );

    exec_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    exec_branch u_branch (
        .pc      (br_pc),
        .imm     (br_imm),
        .src1    (br_ops.src1),
        .src2    (br_ops.src2),
        .mtvec   (br_ops.mtvec),
        .mepc    (br_ops.mepc),
        .br_op   (br_op),
        .sys_op  (sys_op),
        .next_pc (next_pc),
        .link    (link)
    );

endmodule

`default_nettype wire

/* bench/exec_ref.svh */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// ********************
// Random source
// ********************

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// ********************
// Reference model
// ********************

// Signed less-than from the sign bits.
function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic logic [31:0] alu_model(
    input alu_op_e     op,
    input logic [31:0] a,
    input logic [31:0] b
);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    case (op)
        alu_add:    r = a + b;
        alu_sub:    r = a + ~b + 32'd1;
        alu_sll:    r = a << sh;
        alu_slt:    r = less_signed(a, b) ? 32'd1 : 32'd0;
        alu_sltu:   r = (a < b) ? 32'd1 : 32'd0;
        alu_xor:    r = a ^ b;
        alu_srl:    r = a >> sh;
        alu_sra:    r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
        alu_or:     r = a | b;
        alu_and:    r = a & b;
        alu_pass_b: r = b;
        default:    r = 32'd0;
    endcase
    return r;
endfunction

function automatic logic branch_taken(
    input br_op_e      op,
    input logic [31:0] s1,
    input logic [31:0] s2
);
    case (op)
        br_beq:  return s1 == s2;
        br_bne:  return s1 != s2;
        br_blt:  return less_signed(s1, s2);
        br_bge:  return !less_signed(s1, s2);
        br_bltu: return s1 < s2;
        br_bgeu: return s1 >= s2;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] next_pc_model(
    input dec_to_exu_t d,
    input reg_to_exu_t o,
    input logic [31:0] p
);
    logic [31:0] sum;
    sum = o.src1 + d.imm;
    if (d.sys_op == sys_ecall) return o.mtvec;
    if (d.sys_op == sys_mret) return o.mepc;
    if (d.br_op == br_jal) return p + d.imm;
    if (d.br_op == br_jalr) return {sum[31:1], 1'b0};
    if (branch_taken(d.br_op, o.src1, o.src2)) return p + d.imm;
    return p + 32'd4;
endfunction

function automatic logic [31:0] result_model(
    input dec_to_exu_t d,
    input reg_to_exu_t o,
    input logic [31:0] p
);
    if (d.br_op == br_jal || d.br_op == br_jalr) return p + 32'd4;
    return alu_model(d.alu_op, d.src1_is_pc ? p : o.src1, d.src2_is_imm ? d.imm : o.src2);
endfunction

`endif

/* bench/exec_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_tb import exec_pkg::*; ();

    `include "exec_ref.svh"

    localparam int num_tests  = 400;
    localparam int clk_period = 4;

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            in_ready;
    dec_to_exu_t     dec;
    reg_to_exu_t     ops;
    logic [31:0]     pc;
    logic            out_valid;
    logic            out_ready;
    exu_to_lsu_t     lsu;
    logic [31:0]     dnpc;

    logic [31:0]     rng;
    exu_to_lsu_t     exp_lsu_q[$];
    logic [31:0]     exp_dnpc_q[$];
    exu_to_lsu_t     exp_lsu;
    logic [31:0]     exp_dnpc;
    logic            exp_valid;
    exu_to_lsu_t     lsu_q;
    logic [31:0]     dnpc_q;
    int              sent;
    int              done;

    exec_unit_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .dec       (dec),
        .ops       (ops),
        .pc        (pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .lsu       (lsu),
        .dnpc      (dnpc)
    );

    always #(clk_period / 2) clk = ~clk;

    // Output delayed by one edge for the stall checks.
    always @(posedge clk) begin
        lsu_q  <= lsu;
        dnpc_q <= dnpc;
    end

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic protocol_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "%s", what);
    endtask

    // Random instruction with about half plain ALU work.
    task automatic make_instr();
        logic [31:0] r;
        r = next_random();
        dec.imm         = next_random();
        dec.alu_op      = alu_op_e'(4'(next_random() % 11));
        dec.src1_is_pc  = r[0];
        dec.src2_is_imm = r[1];
        dec.halt        = r[2];
        dec.br_op       = br_none;
        dec.sys_op      = sys_none;
        case (r[6:4])
            3'd4, 3'd5: dec.br_op = br_op_e'(4'(32'd1 + next_random() % 6));
            3'd6:       dec.br_op = r[8] ? br_jal : br_jalr;
            3'd7: begin
                dec.sys_op = r[8] ? sys_ecall : sys_mret;
                dec.br_op  = br_op_e'(4'(next_random() % 9));
            end
            default: ;
        endcase
        ops.src1  = next_random();
        // Equal operands now and then so beq and bgeu get taken.
        ops.src2  = (r[10:9] == 2'd0) ? ops.src1 : next_random();
        ops.mtvec = next_random();
        ops.mepc  = next_random();
        pc        = next_random() & 32'hffff_fffc;
    endtask

    initial begin
        logic        in_fire;
        logic        out_fire;
        exu_to_lsu_t rec;
        rng       = 32'h9d6c_ace9;
        clk       = 1'b0;
        rst       = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        dec       = '0;
        ops       = '0;
        pc        = '0;
        exp_valid = 1'b0;
        exp_lsu   = '0;
        exp_dnpc  = '0;
        sent      = 0;
        done      = 0;
        #1 rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        while (done < num_tests) begin
            exp_valid = exp_lsu_q.size() != 0;
            if (exp_valid) begin
                exp_lsu  = exp_lsu_q[0];
                exp_dnpc = exp_dnpc_q[0];
            end
            if (!in_valid && sent < num_tests && next_random() % 4 != 0) begin
                make_instr();
                in_valid = 1'b1;
            end
            out_ready = (next_random() % 3) != 0;
            in_fire   = in_valid && in_ready;
            out_fire  = out_valid && out_ready;
            @(posedge clk);
            #1;
            if (in_fire) begin
                rec.result     = result_model(dec, ops, pc);
                rec.store_data = ops.src2;
                rec.halt       = dec.halt;
                exp_lsu_q.push_back(rec);
                exp_dnpc_q.push_back(next_pc_model(dec, ops, pc));
                sent++;
                in_valid = 1'b0;
            end
            if (out_fire) begin
                void'(exp_lsu_q.pop_front());
                void'(exp_dnpc_q.pop_front());
                done++;
            end
        end
        exp_valid = exp_lsu_q.size() != 0;
        repeat (4) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(num_tests * 20 * clk_period);
        $display("Timeout with %0d of %0d results seen", done, num_tests);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    // ********************
    // Reset checks
    // ********************

    reset_ctrl: assert property (@(posedge clk) rst |-> !out_valid && in_ready)
        else protocol_error("out_valid or in_ready wrong during reset");
    reset_result: assert property (@(posedge clk) rst |-> lsu.result == '0)
        else value_error("lsu.result", 32'd0, lsu.result);
    reset_store: assert property (@(posedge clk) rst |-> lsu.store_data == '0)
        else value_error("lsu.store_data", 32'd0, lsu.store_data);
    reset_halt: assert property (@(posedge clk) rst |-> !lsu.halt)
        else value_error("lsu.halt", 32'd0, {31'b0, lsu.halt});
    reset_dnpc: assert property (@(posedge clk) rst |-> dnpc == '0)
        else value_error("dnpc", 32'd0, dnpc);

    // ********************
    // Output record
    // ********************

    out_expected: assert property (@(posedge clk) disable iff (rst) out_valid |-> exp_valid)
        else protocol_error("output offered with no accepted instruction pending");
    out_result: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> lsu.result == exp_lsu.result)
        else value_error("lsu.result", exp_lsu.result, lsu.result);
    out_store: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> lsu.store_data == exp_lsu.store_data)
        else value_error("lsu.store_data", exp_lsu.store_data, lsu.store_data);
    out_halt: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> lsu.halt == exp_lsu.halt)
        else value_error("lsu.halt", {31'b0, exp_lsu.halt}, {31'b0, lsu.halt});
    out_dnpc: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> dnpc == exp_dnpc)
        else value_error("dnpc", exp_dnpc, dnpc);

    // ********************
    // Handshake
    // ********************

    accept_busy: assert property (@(posedge clk) disable iff (rst)
        $past(in_valid && in_ready) |-> !in_ready && !out_valid)
        else protocol_error("in_ready still high or out_valid early after acceptance");
    valid_latency: assert property (@(posedge clk) disable iff (rst)
        $past(in_valid && in_ready, 2) |-> out_valid)
        else protocol_error("out_valid missing one cycle after acceptance");
    valid_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(out_valid) |-> $past(in_valid && in_ready, 2))
        else protocol_error("out_valid rose without acceptance two edges back");
    busy_ready: assert property (@(posedge clk) disable iff (rst) out_valid |-> !in_ready)
        else protocol_error("in_ready high while output pending");
    release_ready: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && out_ready) |-> in_ready && !out_valid)
        else protocol_error("stage did not return to idle after output transfer");
    hold_valid: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && !out_ready) |-> out_valid)
        else protocol_error("out_valid dropped while stalled");
    hold_result: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && !out_ready) |-> lsu.result == lsu_q.result)
        else value_error("lsu.result", $sampled(lsu_q.result), $sampled(lsu.result));
    hold_store: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && !out_ready) |-> lsu.store_data == lsu_q.store_data)
        else value_error("lsu.store_data", $sampled(lsu_q.store_data),
                         $sampled(lsu.store_data));
    hold_halt: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && !out_ready) |-> lsu.halt == lsu_q.halt)
        else value_error("lsu.halt", {31'b0, $sampled(lsu_q.halt)},
                         {31'b0, $sampled(lsu.halt)});
    hold_dnpc: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && !out_ready) |-> dnpc == dnpc_q)
        else value_error("dnpc", $sampled(dnpc_q), $sampled(dnpc));

endmodule

`default_nettype wire

/* exec_unit.f */
+incdir+bench
design/exec_pkg.sv
design/exec_alu.sv
design/exec_branch.sv
design/exec_stage.sv
design/exec_unit_top.sv
bench/exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# The exit status of the simulation is the exit status of this script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module exec_tb \
    --Mdir obj_dir -o exec_tb_sim \
    -f exec_unit.f

./obj_dir/exec_tb_sim
